/* all.f */
+incdir+.
rtg_pixel_pkg.sv
rtg_cfg_pkg.sv
rtg_pixel_timing.sv
rtg_word_fifo.sv
rtg_fetch_stream.sv
rtg_palette.sv
rtg_video_out.sv
rtg_display_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_rtg_display.sv

/* rtg_cfg_pkg.sv */
`include "rtg_defines.svh"

// Settings the CPU side programs for the RTG screen
package rtg_cfg_pkg;

  typedef logic [`RTG_PIX_CNT_W-1:0] pix_width_t;    // Clocks per fetch minus one
  typedef logic [`RTG_VB_W-1:0]      vbend_t;        // Blanked lines after chipset vblank
  typedef logic [`RTG_ADDR_W-1:4]    base_addr_t;    // Frame base, 16-byte aligned
  typedef logic [`RTG_ADDR_W-1:0]    mem_addr_t;     // Full byte address

  // Source of the colour shown on a pixel
  typedef enum logic [1:0] {
    VID_CHIP    = 2'd0,   // Chipset video
    VID_HICOLOR = 2'd1,   // RGB565 from frame memory
    VID_CLUT    = 2'd2    // Indexed through palette
  } vid_src_t;

  // Palette entry as written by the CPU
  typedef struct packed {
    logic [`RTG_COLOR_W-1:0] r;
    logic [`RTG_COLOR_W-1:0] g;
    logic [`RTG_COLOR_W-1:0] b;
  } pal_entry_t;

endpackage

/* rtg_defines.svh */
`ifndef RTG_DEFINES_SVH
`define RTG_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Memory side
//////////////////////////////////////////////////////////////////////

`define RTG_ADDR_W       25   // Byte address into frame memory
`define RTG_WORD_W       16   // One frame word
`define RTG_FIFO_DEPTH   8    // FIFO entries, also the starting credits

//////////////////////////////////////////////////////////////////////
// Display side
//////////////////////////////////////////////////////////////////////

`define RTG_COLOR_W      8    // Per channel
`define RTG_PIX_CNT_W    3    // Clocks-per-fetch counter
`define RTG_VB_W         5    // Lines of extra vblank
`define RTG_CLUT_ENTRIES 256  // Palette size

`endif

/* rtg_display_top.sv */
`timescale 1ns/10ps

module rtg_display_top (
  input  logic                     CLK_114,
  input  logic                     reset,
  input  logic                     rtg_ena,      // RTG screen on
  input  logic                     rtg_clut,
  input  logic                     rtg_ext,
  input  rtg_cfg_pkg::pix_width_t  pix_width,
  input  rtg_cfg_pkg::vbend_t      vbend,
  input  rtg_cfg_pkg::base_addr_t  base_addr,
  input  logic                     pal_we,       // Palette write port
  input  rtg_pixel_pkg::clut_idx_t pal_idx,
  input  rtg_pixel_pkg::color_t    pal_r,
  input  rtg_pixel_pkg::color_t    pal_g,
  input  rtg_pixel_pkg::color_t    pal_b,
  input  rtg_pixel_pkg::color_t    chip_r,       // Chipset video
  input  rtg_pixel_pkg::color_t    chip_g,
  input  rtg_pixel_pkg::color_t    chip_b,
  input  logic                     chip_hs,
  input  logic                     chip_vs,
  input  logic                     chip_cs,
  input  logic                     hblank,
  input  logic                     vblank,
  input  logic                     osd_window,
  input  logic                     osd_pixel,
  input  logic                     mem_rd_valid,
  input  rtg_pixel_pkg::mem_word_t mem_rd_data,
  output logic                     mem_req,
  output rtg_cfg_pkg::mem_addr_t   mem_addr,
  output rtg_pixel_pkg::color_t    vga_r,
  output rtg_pixel_pkg::color_t    vga_g,
  output rtg_pixel_pkg::color_t    vga_b,
  output logic                     vga_hs,
  output logic                     vga_vs,
  output logic                     vga_cs
);

  import rtg_pixel_pkg::*;

  logic      restart;        // Stream held at frame start
  logic      pixel_strobe;
  logic      rtg_blank;
  logic      hi_byte_sel;
  mem_word_t pixel_word;     // FIFO head
  clut_idx_t clut_idx;
  color_t    clut_r, clut_g, clut_b;

  assign restart = vblank | ~rtg_ena;

  rtg_pixel_timing timing_i (
    .CLK_114      (CLK_114),
    .reset        (reset),
    .rtg_ena      (rtg_ena),
    .rtg_ext      (rtg_ext),
    .pix_width    (pix_width),
    .vbend        (vbend),
    .hblank       (hblank),
    .vblank       (vblank),
    .hsync        (chip_hs),
    .pixel_strobe (pixel_strobe),
    .rtg_blank    (rtg_blank),
    .hi_byte_sel  (hi_byte_sel)
  );

  rtg_fetch_stream stream_i (
    .CLK_114      (CLK_114),
    .reset        (reset),
    .restart      (restart),
    .base_addr    (base_addr),
    .pixel_strobe (pixel_strobe),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_data  (mem_rd_data),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .pixel_word   (pixel_word)
  );

  rtg_palette palette_i (
    .CLK_114 (CLK_114),
    .wr_en   (pal_we),
    .wr_idx  (pal_idx),
    .wr_r    (pal_r),
    .wr_g    (pal_g),
    .wr_b    (pal_b),
    .rd_idx  (clut_idx),
    .rd_r    (clut_r),
    .rd_g    (clut_g),
    .rd_b    (clut_b)
  );

  rtg_video_out video_i (
    .CLK_114     (CLK_114),
    .reset       (reset),
    .rtg_ena     (rtg_ena),
    .rtg_clut    (rtg_clut),
    .rtg_blank   (rtg_blank),
    .hi_byte_sel (hi_byte_sel),
    .pixel_word  (pixel_word),
    .pal_r       (clut_r),
    .pal_g       (clut_g),
    .pal_b       (clut_b),
    .chip_r      (chip_r),
    .chip_g      (chip_g),
    .chip_b      (chip_b),
    .chip_hs     (chip_hs),
    .chip_vs     (chip_vs),
    .chip_cs     (chip_cs),
    .osd_window  (osd_window),
    .osd_pixel   (osd_pixel),
    .clut_idx    (clut_idx),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_cs      (vga_cs)
  );

endmodule

/* rtg_fetch_stream.sv */
`timescale 1ns/10ps

`include "rtg_defines.svh"

module rtg_fetch_stream (
  input  logic                     CLK_114,
  input  logic                     reset,
  input  logic                     restart,       // Hold at frame start
  input  rtg_cfg_pkg::base_addr_t  base_addr,
  input  logic                     pixel_strobe,  // Consume one word
  input  logic                     mem_rd_valid,
  input  rtg_pixel_pkg::mem_word_t mem_rd_data,
  output logic                     mem_req,
  output rtg_cfg_pkg::mem_addr_t   mem_addr,
  output rtg_pixel_pkg::mem_word_t pixel_word
);

  import rtg_cfg_pkg::*;
  import rtg_pixel_pkg::*;

  localparam int CNT_W = $clog2(`RTG_FIFO_DEPTH) + 1;
  typedef logic [CNT_W-1:0] cnt_t;

  mem_addr_t lin_addr;     // Unmangled next address
  cnt_t      credit;       // Free FIFO slots not yet requested
  cnt_t      in_flight;    // Requests still to return
  cnt_t      discard;      // Returns left over from before restart
  logic      running;      // Low for one clock after reset or restart
  logic      fifo_empty;
  logic      do_pop;
  logic      stale;
  logic      fresh;

  assign mem_req = running && !restart && (credit != '0);
  assign do_pop  = pixel_strobe && !fifo_empty;
  assign stale   = mem_rd_valid && (restart || discard != '0);
  assign fresh   = mem_rd_valid && !stale;

  // CPU address mangling, bit 23 only
  assign mem_addr = {lin_addr[24], lin_addr[23] ^ (lin_addr[22] | lin_addr[21]),
                     lin_addr[22:0]};

  //////////////////////////////////////////////////////////////////////
  // Address, credits and stale returns
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (reset) begin
      running   <= 1'b0;
      lin_addr  <= '0;
      credit    <= cnt_t'(`RTG_FIFO_DEPTH);
      in_flight <= '0;
      discard   <= '0;
    end else begin
      running <= !restart;
      case ({mem_req, mem_rd_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: ;
      endcase
      if (restart) begin
        lin_addr <= {base_addr, 4'b0000};                       // Back to frame start
        discard  <= in_flight - cnt_t'(mem_rd_valid);           // Everything out is stale
        credit   <= cnt_t'(`RTG_FIFO_DEPTH) - (in_flight - cnt_t'(mem_rd_valid));
      end else begin
        if (mem_req)
          lin_addr <= lin_addr + 2'd2;                          // Next word
        if (stale)
          discard <= discard - 1'b1;
        credit <= credit + cnt_t'(do_pop) + cnt_t'(stale) - cnt_t'(mem_req);
      end
    end
  end

  rtg_word_fifo fifo_i (
    .CLK_114   (CLK_114),
    .reset     (reset),
    .flush     (restart),
    .push      (fresh),
    .push_data (mem_rd_data),
    .pop       (pixel_strobe),
    .head_data (pixel_word),
    .empty     (fifo_empty)
  );

endmodule

/* rtg_palette.sv */
`timescale 1ns/10ps

`include "rtg_defines.svh"

module rtg_palette (
  input  logic                     CLK_114,
  input  logic                     wr_en,     // CPU palette write
  input  rtg_pixel_pkg::clut_idx_t wr_idx,
  input  rtg_pixel_pkg::color_t    wr_r,
  input  rtg_pixel_pkg::color_t    wr_g,
  input  rtg_pixel_pkg::color_t    wr_b,
  input  rtg_pixel_pkg::clut_idx_t rd_idx,    // From the pixel word
  output rtg_pixel_pkg::color_t    rd_r,
  output rtg_pixel_pkg::color_t    rd_g,
  output rtg_pixel_pkg::color_t    rd_b
);

  import rtg_cfg_pkg::*;

  pal_entry_t clut [`RTG_CLUT_ENTRIES];   // 24-bit RGB per entry
  pal_entry_t rd_entry;

  // Write port
  always_ff @(posedge CLK_114) begin
    if (wr_en)
      clut[wr_idx] <= {wr_r, wr_g, wr_b};
  end

  // Asynchronous read, result lands in the output register downstream
  assign rd_entry = clut[rd_idx];

  assign rd_r = rd_entry.r;
  assign rd_g = rd_entry.g;
  assign rd_b = rd_entry.b;

endmodule

/* rtg_pixel_pkg.sv */
`include "rtg_defines.svh"

// Types for data moving down the pixel path
package rtg_pixel_pkg;

  //////////////////////////////////////////////////////////////////////
  // Memory data
  //////////////////////////////////////////////////////////////////////

  typedef logic [`RTG_WORD_W-1:0] mem_word_t;   // Frame word, RGB565 or two indices

  //////////////////////////////////////////////////////////////////////
  // Colour
  //////////////////////////////////////////////////////////////////////

  typedef logic [`RTG_COLOR_W-1:0] color_t;     // One channel

  // Palette index, sized from entry count
  typedef logic [$clog2(`RTG_CLUT_ENTRIES)-1:0] clut_idx_t;

  typedef logic [1:0] osd2_t;                   // OSD channel, top two bits

  //////////////////////////////////////////////////////////////////////
  // Timing
  //////////////////////////////////////////////////////////////////////

  typedef logic [`RTG_PIX_CNT_W-1:0] pix_cnt_t; // Clocks since last fetch

endpackage

/* rtg_pixel_timing.sv */
`timescale 1ns/10ps

module rtg_pixel_timing (
  input  logic                    CLK_114,
  input  logic                    reset,
  input  logic                    rtg_ena,
  input  logic                    rtg_ext,     // Stretch active area by one clock
  input  rtg_cfg_pkg::pix_width_t pix_width,
  input  rtg_cfg_pkg::vbend_t     vbend,
  input  logic                    hblank,      // Chipset blanking
  input  logic                    vblank,
  input  logic                    hsync,
  output logic                    pixel_strobe,
  output logic                    rtg_blank,
  output logic                    hi_byte_sel
);

  import rtg_cfg_pkg::*;
  import rtg_pixel_pkg::*;

  pix_cnt_t pix_ctr;      // Compared against pix_width
  logic     blank_d;      // Blank one clock back
  logic     byte_sel;     // Second index of the word
  logic     byte_sel_d;
  logic     rtg_vblank;   // Vblank counted in lines
  vbend_t   vb_ctr;
  logic     hsync_d;      // Edge detect

  assign rtg_blank = rtg_vblank | hblank;

  // Fetch strobe, with the one-clock extension past the blank edge
  assign pixel_strobe = rtg_ena && (pix_ctr == pix_width) &&
                        (!rtg_blank || (rtg_ext && !blank_d));

  assign hi_byte_sel = byte_sel_d;   // Lines up with the popped word

  //////////////////////////////////////////////////////////////////////
  // Fetch clock and byte select
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (reset) begin
      pix_ctr    <= '0;
      blank_d    <= 1'b0;
      byte_sel   <= 1'b0;
      byte_sel_d <= 1'b0;
    end else begin
      blank_d    <= rtg_blank;
      byte_sel_d <= byte_sel;
      if (pix_ctr == pix_cnt_t'(pix_width >> 1))
        byte_sel <= 1'b1;                 // Halfway through the fetch period
      if (rtg_blank || pixel_strobe) begin
        pix_ctr  <= '0;                   // Restart period
        byte_sel <= 1'b0;
      end else begin
        pix_ctr <= pix_ctr + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Vertical blank by line count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (reset) begin
      rtg_vblank <= 1'b1;
      vb_ctr     <= '0;
      hsync_d    <= 1'b0;
    end else begin
      hsync_d <= hsync;
      if (vblank) begin
        rtg_vblank <= 1'b1;               // Follow chipset vblank
        vb_ctr     <= '0;
      end else if (vb_ctr == vbend) begin
        rtg_vblank <= 1'b0;               // Enough lines skipped
      end else if (hsync && !hsync_d) begin
        vb_ctr <= vb_ctr + 1'b1;          // One more line
      end
    end
  end

endmodule

/* rtg_video_out.sv */
`timescale 1ns/10ps

module rtg_video_out (
  input  logic                     CLK_114,
  input  logic                     reset,
  input  logic                     rtg_ena,
  input  logic                     rtg_clut,     // Indexed mode
  input  logic                     rtg_blank,
  input  logic                     hi_byte_sel,
  input  rtg_pixel_pkg::mem_word_t pixel_word,
  input  rtg_pixel_pkg::color_t    pal_r,
  input  rtg_pixel_pkg::color_t    pal_g,
  input  rtg_pixel_pkg::color_t    pal_b,
  input  rtg_pixel_pkg::color_t    chip_r,
  input  rtg_pixel_pkg::color_t    chip_g,
  input  rtg_pixel_pkg::color_t    chip_b,
  input  logic                     chip_hs,
  input  logic                     chip_vs,
  input  logic                     chip_cs,
  input  logic                     osd_window,
  input  logic                     osd_pixel,
  output rtg_pixel_pkg::clut_idx_t clut_idx,
  output rtg_pixel_pkg::color_t    vga_r,
  output rtg_pixel_pkg::color_t    vga_g,
  output rtg_pixel_pkg::color_t    vga_b,
  output logic                     vga_hs,
  output logic                     vga_vs,
  output logic                     vga_cs
);

  import rtg_cfg_pkg::*;
  import rtg_pixel_pkg::*;

  color_t   hc_r, hc_g, hc_b;          // Expanded RGB565
  vid_src_t src;
  color_t   red_reg, grn_reg, blu_reg;
  logic     hs_reg, vs_reg, cs_reg;
  osd2_t    osd_r, osd_g, osd_b;

  assign clut_idx = hi_byte_sel ? pixel_word[15:8] : pixel_word[7:0];

  // Top bits repeated into the low bits
  assign hc_r = {pixel_word[15:11], pixel_word[15:13]};
  assign hc_g = {pixel_word[10:5], pixel_word[10:9]};
  assign hc_b = {pixel_word[4:0], pixel_word[4:2]};

  always_comb begin
    if (rtg_ena && !rtg_blank)
      src = rtg_clut ? VID_CLUT : VID_HICOLOR;
    else
      src = VID_CHIP;                  // Off or blanked
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (reset) begin
      {red_reg, grn_reg, blu_reg} <= '0;
      {hs_reg, vs_reg, cs_reg}    <= '0;
    end else begin
      hs_reg <= chip_hs;
      vs_reg <= chip_vs;
      cs_reg <= chip_cs;
      case (src)
        VID_CLUT:    {red_reg, grn_reg, blu_reg} <= {pal_r, pal_g, pal_b};
        VID_HICOLOR: {red_reg, grn_reg, blu_reg} <= {hc_r, hc_g, hc_b};
        default:     {red_reg, grn_reg, blu_reg} <= {chip_r, chip_g, chip_b};
      endcase
    end
  end

  // OSD colour, white text on dark blue
  assign osd_r = osd_pixel ? 2'b11 : 2'b00;
  assign osd_g = osd_pixel ? 2'b11 : 2'b00;
  assign osd_b = osd_pixel ? 2'b11 : 2'b10;

  assign vga_r  = osd_window ? {osd_r, red_reg[7:2]} : red_reg;
  assign vga_g  = osd_window ? {osd_g, grn_reg[7:2]} : grn_reg;
  assign vga_b  = osd_window ? {osd_b, blu_reg[7:2]} : blu_reg;
  assign vga_hs = hs_reg;
  assign vga_vs = vs_reg;
  assign vga_cs = cs_reg;

endmodule

/* rtg_word_fifo.sv */
`timescale 1ns/10ps

`include "rtg_defines.svh"

module rtg_word_fifo (
  input  logic                     CLK_114,
  input  logic                     reset,
  input  logic                     flush,       // Drop everything
  input  logic                     push,
  input  rtg_pixel_pkg::mem_word_t push_data,
  input  logic                     pop,
  output rtg_pixel_pkg::mem_word_t head_data,   // Valid unless empty
  output logic                     empty
);

  import rtg_pixel_pkg::*;

  localparam int PTR_W = $clog2(`RTG_FIFO_DEPTH);

  mem_word_t        mem [`RTG_FIFO_DEPTH];
  logic [PTR_W:0]   wr_ptr;    // Top bit tells wraps apart
  logic [PTR_W:0]   rd_ptr;
  logic             do_pop;

  assign empty     = (wr_ptr == rd_ptr);
  assign do_pop    = pop && !empty;          // Empty pops ignored
  assign head_data = mem[rd_ptr[PTR_W-1:0]];

  // Storage, no flush needed on data
  always_ff @(posedge CLK_114) begin
    if (push)
      mem[wr_ptr[PTR_W-1:0]] <= push_data;
  end

  always_ff @(posedge CLK_114) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the RTG display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_rtg_display -o sim_rtg

# Keep going after a failing run so the log decides
./obj_dir/sim_rtg > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if ! grep -q "Regression passed" sim.log; then
  exit 1
fi
exit 0

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic CLK_114,
  output logic reset
);

  initial begin
    CLK_114 = 1'b0;
    forever #4 CLK_114 = ~CLK_114;   // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge CLK_114);
    reset <= 1'b0;                   // Released after 8 cycles
  end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
  input  logic                     CLK_114,
  input  logic                     reset,
  input  logic                     mem_req,
  input  rtg_cfg_pkg::mem_addr_t   mem_addr,
  output logic                     mem_rd_valid,
  output rtg_pixel_pkg::mem_word_t mem_rd_data,
  output int                       outstanding    // Requests not yet returned
);

  import rtg_cfg_pkg::*;
  import rtg_pixel_pkg::*;

  mem_addr_t   addr_q [$];    // Pending requests, in order
  longint      due_q [$];     // Cycle each one returns
  longint      cyc;
  longint      last_due;
  logic [31:0] lcg_state;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Frame content, low address bits times an odd constant
  function automatic mem_word_t word_at(input mem_addr_t a);
    logic [15:0] lo;
    lo = a[15:0];
    return lo * 16'h9e37;
  endfunction

  always @(posedge CLK_114) begin
    longint    due;
    mem_addr_t ra;
    if (reset) begin
      addr_q.delete();
      due_q.delete();
      cyc          = 0;
      last_due     = 0;
      lcg_state    = 32'h06e186f8;
      mem_rd_valid <= 1'b0;
      mem_rd_data  <= '0;
      outstanding  <= 0;
    end else begin
      cyc = cyc + 1;
      mem_rd_valid <= 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin   // Oldest one is due
        ra = addr_q.pop_front();
        void'(due_q.pop_front());
        mem_rd_valid <= 1'b1;
        mem_rd_data  <= word_at(ra);
      end
      if (mem_req) begin
        lcg_state = lcg_next(lcg_state);
        due = cyc + 1 + longint'(lcg_state[17:16]);    // 1 to 4 cycles
        if (due <= last_due)
          due = last_due + 1;                           // Keep order, one per cycle
        last_due = due;
        addr_q.push_back(mem_addr);
        due_q.push_back(due);
      end
      outstanding <= addr_q.size();
    end
  end

endmodule

/* tb_rtg_display.sv */
`timescale 1ns/10ps

`include "rtg_defines.svh"

module tb_rtg_display;

  import rtg_cfg_pkg::*;
  import rtg_pixel_pkg::*;

  localparam int LINE_LEN   = 48;
  localparam int HBLANK_END = 12;   // hblank for columns below this
  localparam int HSYNC_END  = 4;
  localparam int VB_LINES   = 2;    // Chipset vblank lines per frame
  localparam int FRAMES     = 2;
  localparam int ROWS       = 6;

  typedef struct packed {
    logic        ena;
    logic        clut;
    pix_width_t  pw;
    vbend_t      vbend;
    base_addr_t  base;
    logic        osd;
    logic [23:0] chip;
    logic [5:0]  lines;
  } row_t;

  typedef struct packed {
    logic        valid;
    logic [23:0] rgb;
    logic        hs;
    logic        vs;
    logic        cs;
  } exp_t;

  logic CLK_114, reset;
  logic rtg_ena, rtg_clut, rtg_ext, pal_we;
  pix_width_t pix_width;
  vbend_t vbend;
  base_addr_t base_addr;
  clut_idx_t pal_idx;
  color_t pal_r, pal_g, pal_b, chip_r, chip_g, chip_b;
  logic chip_hs, chip_vs, chip_cs, hblank, vblank, osd_window, osd_pixel;
  logic mem_rd_valid, mem_req;
  mem_word_t mem_rd_data;
  mem_addr_t mem_addr;
  color_t vga_r, vga_g, vga_b;
  logic vga_hs, vga_vs, vga_cs;
  int outstanding;

  row_t        table_rows [ROWS];
  logic [23:0] pal_model [256];   // Palette as written
  logic [31:0] lcg_state;
  exp_t        exp_d1, exp_d2;    // Expected register contents by drive age
  int          words_popped;
  pix_cnt_t    ctr_m;             // Fetch period model
  logic        bs_m, bsd_m;
  int          req_idx;

  tb_clock_gen clk_i (.CLK_114(CLK_114), .reset(reset));

  tb_mem_model mem_i (
    .CLK_114(CLK_114), .reset(reset), .mem_req(mem_req), .mem_addr(mem_addr),
    .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data), .outstanding(outstanding)
  );

  rtg_display_top dut_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic mem_addr_t mangle(input mem_addr_t a);
    mem_addr_t m;
    m = a;
    m[23] = a[23] ^ (a[22] | a[21]);   // CPU address mangling
    return m;
  endfunction

  function automatic mem_word_t word_at(input mem_addr_t a);
    logic [15:0] lo;
    lo = a[15:0];
    return lo * 16'h9e37;
  endfunction

  function automatic logic [23:0] expand565(input mem_word_t w);
    return {w[15:11], w[15:13], w[10:5], w[10:9], w[4:0], w[4:2]};
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    assert (got === expected)
      else report_fail($sformatf("Fail %s expected %h got %h", name, expected, got));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output checks, once per rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic check_outputs();
    color_t    er, eg, eb;
    mem_addr_t ea;
    if (exp_d2.valid) begin
      er = exp_d2.rgb[23:16];
      eg = exp_d2.rgb[15:8];
      eb = exp_d2.rgb[7:0];
      if (osd_window) begin                          // Overlay follows current inputs
        er = {(osd_pixel ? 2'b11 : 2'b00), er[7:2]};
        eg = {(osd_pixel ? 2'b11 : 2'b00), eg[7:2]};
        eb = {(osd_pixel ? 2'b11 : 2'b10), eb[7:2]};
      end
      check_value("vga_r", 32'(er), 32'(vga_r));
      check_value("vga_g", 32'(eg), 32'(vga_g));
      check_value("vga_b", 32'(eb), 32'(vga_b));
      check_value("vga_hs", 32'(exp_d2.hs), 32'(vga_hs));
      check_value("vga_vs", 32'(exp_d2.vs), 32'(vga_vs));
      check_value("vga_cs", 32'(exp_d2.cs), 32'(vga_cs));
    end
    if (vblank || !rtg_ena) begin
      req_idx = 0;                                   // Stream back at base
    end else if (mem_req) begin
      ea = mangle(mem_addr_t'({base_addr, 4'b0000}) + mem_addr_t'(2 * req_idx));
      check_value("mem_addr", 32'(ea), 32'(mem_addr));
      req_idx++;
    end
    assert (outstanding <= `RTG_FIFO_DEPTH)
      else report_fail($sformatf("More requests outstanding (%0d) than FIFO entries",
                                 outstanding));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive one cycle and predict its registered result
  //////////////////////////////////////////////////////////////////////

  task automatic apply_cycle(input row_t r, input int line, input int col,
                             input logic pal_phase, input int pal_i);
    logic        vb, hb, hs, ena, blank, strobe, bs_n;
    logic [7:0]  c8;
    logic [23:0] chip, rgb, pal_col;
    mem_word_t   w;
    int          first;
    c8    = col[7:0];
    vb    = pal_phase || line < VB_LINES;
    hb    = pal_phase || col < HBLANK_END;
    hs    = !pal_phase && col < HSYNC_END;
    ena   = r.ena && !pal_phase;
    chip  = r.chip ^ {c8, c8, c8};                   // Varies along the line
    first = VB_LINES + ((r.vbend == '0) ? 0 : int'(r.vbend) - 1);
    blank = !(!pal_phase && line >= first && col >= HBLANK_END);
    if (pal_phase) begin
      lcg_state = lcg_next(lcg_state);
      pal_col   = lcg_state[31:8];
      pal_model[pal_i] = pal_col;
    end else begin
      pal_col = '0;
    end
    rtg_ena    <= ena;
    rtg_clut   <= r.clut;
    pix_width  <= r.pw;
    vbend      <= r.vbend;
    base_addr  <= r.base;
    pal_we     <= pal_phase;
    pal_idx    <= clut_idx_t'(pal_i);
    {pal_r, pal_g, pal_b} <= pal_col;
    {chip_r, chip_g, chip_b} <= chip;
    chip_hs    <= hs;
    chip_vs    <= vb;
    chip_cs    <= hs ^ vb;
    hblank     <= hb;
    vblank     <= vb;
    osd_window <= r.osd && !pal_phase && line >= 3 && col >= 20 && col < 36;
    osd_pixel  <= col[1] ^ line[0];
    // Colour this cycle should produce
    if (ena && !blank) begin
      w = word_at(mangle(mem_addr_t'({r.base, 4'b0000}) + mem_addr_t'(2 * words_popped)));
      rgb = r.clut ? pal_model[bsd_m ? w[15:8] : w[7:0]] : expand565(w);
    end else begin
      rgb = chip;
    end
    exp_d2 = exp_d1;
    exp_d1 = '{valid: 1'b1, rgb: rgb, hs: hs, vs: vb, cs: hs ^ vb};
    // Fetch period and byte select rules
    strobe = ena && !blank && (ctr_m == r.pw);
    bs_n   = (ctr_m == (r.pw >> 1)) ? 1'b1 : bs_m;
    bsd_m  = bs_m;
    if (blank || strobe) begin
      ctr_m = '0;
      bs_n  = 1'b0;
    end else begin
      ctr_m = ctr_m + 3'd1;
    end
    bs_m = bs_n;
    if (strobe)
      words_popped++;
    if (vb || !ena)
      words_popped = 0;                              // Restart flushes the FIFO
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and run
  //////////////////////////////////////////////////////////////////////

  initial begin
    row_t row;
    table_rows[0] = '{1'b0, 1'b0, 3'd0, 5'd0, 21'h000000, 1'b0, 24'h123456, 6'd5};
    table_rows[1] = '{1'b1, 1'b0, 3'd1, 5'd1, 21'h020010, 1'b0, 24'h0f0f0f, 6'd8};
    table_rows[2] = '{1'b1, 1'b0, 3'd3, 5'd2, 21'h048000, 1'b1, 24'h336699, 6'd8};
    table_rows[3] = '{1'b1, 1'b1, 3'd1, 5'd1, 21'h100400, 1'b0, 24'h00ff00, 6'd8};
    table_rows[4] = '{1'b1, 1'b1, 3'd2, 5'd3, 21'h0a0fff, 1'b1, 24'h808080, 6'd9};
    table_rows[5] = '{1'b0, 1'b0, 3'd0, 5'd0, 21'h000000, 1'b1, 24'ha5c33c, 6'd5};
    {rtg_clut, rtg_ext, pal_we} = '0;
    rtg_ena = 1'b1;                                  // Stream free to request out of reset
    {pix_width, vbend, base_addr, pal_idx} = '0;
    {pal_r, pal_g, pal_b} = '0;
    {chip_r, chip_g, chip_b} = 24'h5a5a5a;           // Only reset can zero the outputs
    {chip_hs, chip_vs, chip_cs} = 3'b111;
    {osd_window, osd_pixel} = '0;
    hblank = 1'b1;
    vblank = 1'b0;
    lcg_state    = 32'h06e186f8;
    exp_d1       = '0;
    exp_d2       = '0;
    words_popped = 0;
    ctr_m        = '0;
    bs_m         = 1'b0;
    bsd_m        = 1'b0;
    req_idx      = 0;
    wait (reset === 1'b1);
    wait (reset === 1'b0);
    @(posedge CLK_114);
    check_value("mem_req", 32'(0), 32'(mem_req));   // Reset state
    check_value("vga_r", 32'(0), 32'(vga_r));
    check_value("vga_g", 32'(0), 32'(vga_g));
    check_value("vga_b", 32'(0), 32'(vga_b));
    check_value("vga_hs", 32'(0), 32'(vga_hs));
    check_value("vga_vs", 32'(0), 32'(vga_vs));
    check_value("vga_cs", 32'(0), 32'(vga_cs));
    for (int ri = 0; ri < ROWS; ri++) begin
      row = table_rows[ri];
      if (row.clut) begin
        for (int p = 0; p < 256; p++) begin          // Load palette first
          @(posedge CLK_114);
          check_outputs();
          apply_cycle(row, 0, 0, 1'b1, p);
        end
      end
      for (int f = 0; f < FRAMES; f++)
        for (int ln = 0; ln < int'(row.lines); ln++)
          for (int col = 0; col < LINE_LEN; col++) begin
            @(posedge CLK_114);
            check_outputs();
            apply_cycle(row, ln, col, 1'b0, 0);
          end
    end
    repeat (3) begin                                 // Drain the output pipe
      @(posedge CLK_114);
      check_outputs();
      apply_cycle(table_rows[0], 0, 0, 1'b0, 0);
    end
    $display("Regression passed");
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int limit;
    #1;
    limit = 200;
    for (int ri = 0; ri < ROWS; ri++)
      limit += (table_rows[ri].clut ? 256 : 0) +
               FRAMES * int'(table_rows[ri].lines) * LINE_LEN;
    #(limit * 8);
    report_fail("Watchdog expired before the test table finished");
  end

endmodule
